// ==== hdl/kbd_pkg.sv ====
package kbd_pkg;

	// ps/2 frame geometry
	localparam int FRAME_BITS  = 11;
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

	// bit timer, abort a stalled frame after this many clk cycles
	localparam int BIT_TIMEOUT = 400;
	localparam int BIT_TIMER_W = $clog2(BIT_TIMEOUT + 1);

	// scan code set 2
	localparam logic [7:0] SCAN_E0     = 8'hE0; // extended prefix
	localparam logic [7:0] SCAN_F0     = 8'hF0; // break prefix
	localparam logic [7:0] SCAN_LSHIFT = 8'h12;
	localparam logic [7:0] SCAN_RSHIFT = 8'h59;
	localparam logic [7:0] SCAN_CAPS   = 8'h58;

	// prefix FSM states, bit 0 = extended seen, bit 1 = break seen
	localparam logic [1:0] ST_IDLE    = 2'b00;
	localparam logic [1:0] ST_EXT     = 2'b01;
	localparam logic [1:0] ST_BRK     = 2'b10;
	localparam logic [1:0] ST_EXT_BRK = 2'b11;

	// event queue
	localparam int QUEUE_DEPTH   = 8;
	localparam int QUEUE_AW      = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CREDITS = 4;
	localparam int CREDIT_W      = $clog2(QUEUE_CREDITS + 1);
	localparam int EVT_W         = 18; // scan, ascii, release, extended

	// received frame, bit 0 arrives first
	typedef union packed {
		logic [FRAME_BITS-1:0] raw;
		struct packed {
			logic       stop;
			logic       parity;
			logic [7:0] data;
			logic       start;
		} f;
	} ps2_frame_u;

endpackage

// ==== hdl/ps2_frame_rx.sv ====
`timescale 1ns/1ps

module ps2_frame_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	input  logic       bit_timeout,
	output logic       ps2_fall,
	output logic       in_frame,
	output logic       byte_valid,
	output logic [7:0] byte_data,
	output logic       frame_err
);
	import kbd_pkg::*;

	logic clk_meta, clk_sync, clk_last; // two sync stages plus edge history
	logic data_meta, data_sync;
	logic [FRAME_CNT_W-1:0] bit_cnt;
	ps2_frame_u frame_q;
	ps2_frame_u frame_nxt;  // frame including the bit arriving now
	logic last_bit;
	logic frame_ok;

	// both lines idle high, so sync flops come out of reset high
	always_ff @(posedge clk) begin
		if (reset) begin
			clk_meta  <= 1'b1;
			clk_sync  <= 1'b1;
			clk_last  <= 1'b1;
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end else begin
			clk_meta  <= ps2_clk;
			clk_sync  <= clk_meta;
			clk_last  <= clk_sync;
			data_meta <= ps2_data;
			data_sync <= data_meta;
		end
	end

	assign ps2_fall = clk_last & ~clk_sync; // keyboard drives data, we sample on fall
	assign in_frame = (bit_cnt != '0);
	assign last_bit = (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1));

	always_comb begin
		frame_nxt = frame_q;
		frame_nxt.raw[bit_cnt] = data_sync;
	end

	// start low, stop high, odd parity over data and parity bit
	assign frame_ok = !frame_nxt.f.start && frame_nxt.f.stop
		&& (^{frame_nxt.f.parity, frame_nxt.f.data});

	always_ff @(posedge clk) begin
		if (ps2_fall)
			frame_q <= frame_nxt;
		if (ps2_fall && last_bit && frame_ok)
			byte_data <= frame_nxt.f.data; // held until the next good frame
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt    <= '0;
			byte_valid <= 1'b0;
			frame_err  <= 1'b0;
		end else begin
			byte_valid <= ps2_fall && last_bit && frame_ok;
			frame_err  <= ps2_fall && last_bit && !frame_ok;
			if (bit_timeout)
				bit_cnt <= '0; // stalled frame, drop silently
			else if (ps2_fall)
				bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
		end
	end

endmodule

// ==== hdl/ps2_bit_timer.sv ====
`timescale 1ns/1ps

module ps2_bit_timer (
	input  logic clk,
	input  logic reset,
	input  logic ps2_fall,
	input  logic in_frame,
	output logic bit_timeout
);
	import kbd_pkg::*;

	logic [BIT_TIMER_W-1:0] idle_cnt; // cycles since the last ps/2 falling edge

	always_ff @(posedge clk) begin
		if (reset) begin
			idle_cnt    <= '0;
			bit_timeout <= 1'b0;
		end else if (!in_frame || ps2_fall) begin
			idle_cnt    <= '0; // restart on every edge, rest outside a frame
			bit_timeout <= 1'b0;
		end else begin
			bit_timeout <= (idle_cnt == BIT_TIMER_W'(BIT_TIMEOUT - 1));
			// saturate so the pulse fires once
			if (idle_cnt != BIT_TIMER_W'(BIT_TIMEOUT))
				idle_cnt <= idle_cnt + 1'b1;
		end
	end

endmodule

// ==== hdl/kbd_protocol_fsm.sv ====
`timescale 1ns/1ps

module kbd_protocol_fsm (
	input  logic       clk,
	input  logic       reset,
	input  logic       byte_valid,
	input  logic [7:0] byte_data,
	input  logic [7:0] key_ascii,
	output logic [7:0] key_scan,
	output logic       key_extended,
	output logic       shift_active,
	output logic       key_valid,
	output logic [7:0] key_ascii_q,
	output logic       key_release
);
	import kbd_pkg::*;

	logic [1:0] state;
	logic shift_held; // either shift key down
	logic caps_on;
	logic is_prefix;
	logic is_key; // non-prefix byte, ends a sequence
	logic is_shift;

	assign is_prefix = (byte_data == SCAN_E0) || (byte_data == SCAN_F0);
	assign is_key    = byte_valid && !is_prefix;
	assign is_shift  = (byte_data == SCAN_LSHIFT) || (byte_data == SCAN_RSHIFT);

	// byte_data holds until the next frame, so it serves mapper and queue alike
	assign key_scan = byte_data;

	// flags come straight from the state, which stays put through key_valid
	assign key_extended = (state == ST_EXT) || (state == ST_EXT_BRK);
	assign key_release  = (state == ST_BRK) || (state == ST_EXT_BRK);
	assign shift_active = shift_held ^ caps_on; // caps inverts shift

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_IDLE;
			shift_held <= 1'b0;
			caps_on    <= 1'b0;
			key_valid  <= 1'b0;
		end else begin
			key_valid <= is_key;

			if (key_valid)
				state <= ST_IDLE; // event handed over
			else if (byte_valid && byte_data == SCAN_E0 && state == ST_IDLE)
				state <= ST_EXT;
			else if (byte_valid && byte_data == SCAN_F0)
				state <= key_extended ? ST_EXT_BRK : ST_BRK;

			// modifiers only from the main block, E0 12 is a fake shift
			if (is_key && !key_extended) begin
				if (is_shift)
					shift_held <= !key_release; // make sets, break clears
				if (byte_data == SCAN_CAPS && !key_release)
					caps_on <= !caps_on;
			end
		end
	end

	// mapper result sampled with the shift state from before this byte
	always_ff @(posedge clk) begin
		if (is_key)
			key_ascii_q <= key_ascii;
	end

endmodule

// ==== hdl/scan_to_ascii.sv ====
`timescale 1ns/1ps

module scan_to_ascii (
	input  logic [7:0] scan,
	input  logic       extended,
	input  logic       shift_active,
	output logic [7:0] ascii
);

	logic [7:0] lo; // unshifted character
	logic [7:0] hi; // shifted character

	always_comb begin
		lo = 8'h00; // unmapped keys give no character
		hi = 8'h00;
		case (scan)
			// top row digits
			8'h16: {hi, lo} = {8'h21, 8'h31}; // 1 !
			8'h1E: {hi, lo} = {8'h40, 8'h32}; // 2 @
			8'h26: {hi, lo} = {8'h23, 8'h33}; // 3 #
			8'h25: {hi, lo} = {8'h24, 8'h34}; // 4 $
			8'h2E: {hi, lo} = {8'h25, 8'h35}; // 5 %
			8'h36: {hi, lo} = {8'h5E, 8'h36}; // 6 ^
			8'h3D: {hi, lo} = {8'h26, 8'h37}; // 7 &
			8'h3E: {hi, lo} = {8'h2A, 8'h38}; // 8 *
			8'h46: {hi, lo} = {8'h28, 8'h39}; // 9 (
			8'h45: {hi, lo} = {8'h29, 8'h30}; // 0 )
			// letters
			8'h1C: {hi, lo} = {8'h41, 8'h61}; // a
			8'h32: {hi, lo} = {8'h42, 8'h62}; // b
			8'h21: {hi, lo} = {8'h43, 8'h63}; // c
			8'h23: {hi, lo} = {8'h44, 8'h64}; // d
			8'h24: {hi, lo} = {8'h45, 8'h65}; // e
			8'h2B: {hi, lo} = {8'h46, 8'h66}; // f
			8'h34: {hi, lo} = {8'h47, 8'h67}; // g
			8'h33: {hi, lo} = {8'h48, 8'h68}; // h
			8'h43: {hi, lo} = {8'h49, 8'h69}; // i
			8'h3B: {hi, lo} = {8'h4A, 8'h6A}; // j
			8'h42: {hi, lo} = {8'h4B, 8'h6B}; // k
			8'h4B: {hi, lo} = {8'h4C, 8'h6C}; // l
			8'h3A: {hi, lo} = {8'h4D, 8'h6D}; // m
			8'h31: {hi, lo} = {8'h4E, 8'h6E}; // n
			8'h44: {hi, lo} = {8'h4F, 8'h6F}; // o
			8'h4D: {hi, lo} = {8'h50, 8'h70}; // p
			8'h15: {hi, lo} = {8'h51, 8'h71}; // q
			8'h2D: {hi, lo} = {8'h52, 8'h72}; // r
			8'h1B: {hi, lo} = {8'h53, 8'h73}; // s
			8'h2C: {hi, lo} = {8'h54, 8'h74}; // t
			8'h3C: {hi, lo} = {8'h55, 8'h75}; // u
			8'h2A: {hi, lo} = {8'h56, 8'h76}; // v
			8'h1D: {hi, lo} = {8'h57, 8'h77}; // w
			8'h22: {hi, lo} = {8'h58, 8'h78}; // x
			8'h35: {hi, lo} = {8'h59, 8'h79}; // y
			8'h1A: {hi, lo} = {8'h5A, 8'h7A}; // z
			// symbol keys
			8'h0E: {hi, lo} = {8'h7E, 8'h60}; // ` ~
			8'h4E: {hi, lo} = {8'h5F, 8'h2D}; // - _
			8'h55: {hi, lo} = {8'h2B, 8'h3D}; // = +
			8'h54: {hi, lo} = {8'h7B, 8'h5B}; // [ {
			8'h5B: {hi, lo} = {8'h7D, 8'h5D}; // ] }
			8'h5D: {hi, lo} = {8'h7C, 8'h5C}; // \ |
			8'h4C: {hi, lo} = {8'h3A, 8'h3B}; // ; :
			8'h52: {hi, lo} = {8'h22, 8'h27}; // ' "
			8'h41: {hi, lo} = {8'h3C, 8'h2C}; // , <
			8'h49: {hi, lo} = {8'h3E, 8'h2E}; // . >
			8'h4A: {hi, lo} = {8'h3F, 8'h2F}; // / ?
			// control keys, same either way
			8'h29: {hi, lo} = {8'h20, 8'h20}; // space
			8'h66: {hi, lo} = {8'h08, 8'h08}; // backspace
			8'h5A: {hi, lo} = {8'h0D, 8'h0D}; // enter
			8'h76: {hi, lo} = {8'h1B, 8'h1B}; // escape
			default: {hi, lo} = {8'h00, 8'h00};
		endcase
	end

	// arrows, keypad enter etc. share codes with the main block, so no char
	assign ascii = extended ? 8'h00 : (shift_active ? hi : lo);

endmodule

// ==== hdl/key_event_queue.sv ====
`timescale 1ns/1ps

module key_event_queue (
	input  logic       clk,
	input  logic       reset,
	input  logic       key_valid,
	input  logic [7:0] key_scan,
	input  logic [7:0] key_ascii,
	input  logic       key_release,
	input  logic       key_extended,
	input  logic       credit_return,
	output logic       evt_valid,
	output logic [7:0] evt_scan,
	output logic [7:0] evt_ascii,
	output logic       evt_release,
	output logic       evt_extended,
	output logic       overflow
);
	import kbd_pkg::*;

	logic [EVT_W-1:0] mem [QUEUE_DEPTH];
	logic [QUEUE_AW:0] wr_ptr, rd_ptr; // extra msb tells full from empty
	logic [CREDIT_W-1:0] credit_cnt;   // events the consumer can still take
	logic empty, full, push, pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[QUEUE_AW] != rd_ptr[QUEUE_AW])
		&& (wr_ptr[QUEUE_AW-1:0] == rd_ptr[QUEUE_AW-1:0]);
	assign push  = key_valid && !full; // keyboard cannot be stalled, drop instead
	assign pop   = !empty && (credit_cnt != '0);

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[QUEUE_AW-1:0]] <= {key_scan, key_ascii, key_release, key_extended};
		if (pop)
			{evt_scan, evt_ascii, evt_release, evt_extended} <= mem[rd_ptr[QUEUE_AW-1:0]];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			credit_cnt <= CREDIT_W'(QUEUE_CREDITS);
			evt_valid  <= 1'b0;
			overflow   <= 1'b0;
		end else begin
			evt_valid <= pop;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (key_valid && full)
				overflow <= 1'b1; // sticky until reset
			case ({pop, credit_return})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt; // both or neither
			endcase
		end
	end

endmodule

// ==== hdl/kbd_rx_top.sv ====
`timescale 1ns/1ps

module kbd_rx_top (
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	input  logic       credit_return,
	output logic       evt_valid,
	output logic [7:0] evt_scan,
	output logic [7:0] evt_ascii,
	output logic       evt_release,
	output logic       evt_extended,
	output logic       frame_err,
	output logic       overflow
);

	logic       ps2_fall, in_frame, bit_timeout;
	logic       byte_valid;
	logic [7:0] byte_data;
	logic [7:0] key_scan, key_ascii, key_ascii_q;
	logic       key_extended, key_release, key_valid;
	logic       shift_active;

	// pins to bytes
	ps2_frame_rx i_ps2_frame_rx (
		.clk, .reset, .ps2_clk, .ps2_data, .bit_timeout,
		.ps2_fall, .in_frame, .byte_valid, .byte_data, .frame_err
	);

	ps2_bit_timer i_ps2_bit_timer (.clk, .reset, .ps2_fall, .in_frame, .bit_timeout);

	// bytes to key events
	kbd_protocol_fsm i_kbd_protocol_fsm (
		.clk, .reset, .byte_valid, .byte_data, .key_ascii,
		.key_scan, .key_extended, .shift_active, .key_valid, .key_ascii_q, .key_release
	);

	scan_to_ascii i_scan_to_ascii (
		.scan(key_scan), .extended(key_extended), .shift_active, .ascii(key_ascii)
	);

	// events out under credit control
	key_event_queue i_key_event_queue (
		.clk, .reset, .key_valid, .key_scan, .key_ascii(key_ascii_q),
		.key_release, .key_extended, .credit_return,
		.evt_valid, .evt_scan, .evt_ascii, .evt_release, .evt_extended, .overflow
	);

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);
	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end
endmodule

// ==== bench/kbd_rx_checker.sv ====
`timescale 1ns/1ps

module kbd_rx_checker (
	input logic                         clk,
	input logic                         reset,
	input logic                         evt_valid,
	input logic [kbd_pkg::CREDIT_W-1:0] credit_cnt
);
	import kbd_pkg::*;

	// evt_valid follows the pop by one cycle, so look at the credits then
	a_send_needs_credit: assert property (@(posedge clk) disable iff (reset)
		evt_valid |-> $past(credit_cnt) != '0)
		else $error("event sent with no credit");

	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credit_cnt <= CREDIT_W'(QUEUE_CREDITS))
		else $error("credit count above initial credit");

	a_quiet_in_reset: assert property (@(posedge clk)
		(reset && $past(reset)) |-> !evt_valid)
		else $error("evt_valid high during reset");
endmodule

bind key_event_queue kbd_rx_checker i_kbd_rx_checker (.clk, .reset, .evt_valid, .credit_cnt);

// ==== bench/kbd_rx_model.svh ====
`ifndef KBD_RX_MODEL_SVH
`define KBD_RX_MODEL_SVH

// scan codes for a..z and for 1..9,0
localparam logic [7:0] LETTER_SCAN [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
	8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15,
	8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
localparam logic [7:0] DIGIT_SCAN [10] = '{8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
	8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45};

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	return x;
endfunction

// bits go out lsb first with data set while the clock is high and sampled on the fall
task automatic send_raw(input ps2_frame_u fr, input int nbits);
	for (int i = 0; i < nbits; i++) begin
		ps2_data <= fr.raw[i];
		repeat (12) @(posedge clk);
		ps2_clk <= 1'b0;
		repeat (12) @(posedge clk);
		ps2_clk <= 1'b1;
	end
	ps2_data <= 1'b1; // back to idle
	frames_sent++;
	repeat (24) @(posedge clk); // inter-frame gap
endtask

task automatic send_frame(input logic [7:0] b, input logic bad_parity, input logic bad_stop);
	ps2_frame_u fr;
	fr.f.start  = 1'b0;
	fr.f.data   = b;
	fr.f.parity = ~^b ^ bad_parity; // odd parity
	fr.f.stop   = !bad_stop;
	send_raw(fr, FRAME_BITS);
endtask

function automatic logic [7:0] ref_ascii(input logic [7:0] scan, input logic shifted);
	string lo_dig = "1234567890";
	string hi_dig = "!@#$%^&*()";
	for (int i = 0; i < 26; i++)
		if (scan == LETTER_SCAN[i])
			return shifted ? 8'(8'h41 + i) : 8'(8'h61 + i);
	for (int i = 0; i < 10; i++)
		if (scan == DIGIT_SCAN[i])
			return shifted ? hi_dig[i] : lo_dig[i];
	case (scan)
		8'h29: return 8'h20; // space
		8'h66: return 8'h08;
		8'h5A: return 8'h0D;
		8'h76: return 8'h1B;
		default: return 8'h00;
	endcase
endfunction

// expected key event for each byte the keyboard sends
function automatic void ref_event(input logic [7:0] b);
	logic [7:0] asc;
	if (b == SCAN_E0) begin
		ref_ext = 1'b1;
	end else if (b == SCAN_F0) begin
		ref_brk = 1'b1;
	end else begin
		asc = ref_ext ? 8'h00 : ref_ascii(b, ref_shift ^ ref_caps);
		// while credits are held only queue depth plus credits fit
		if (!hold_credits || hold_kept < QUEUE_DEPTH + QUEUE_CREDITS) begin
			sb.push_back({b, asc, ref_brk, ref_ext});
			if (hold_credits)
				hold_kept++;
		end else begin
			exp_overflow = 1'b1; // past capacity the event is lost
		end
		if (!ref_ext && (b == SCAN_LSHIFT || b == SCAN_RSHIFT))
			ref_shift = !ref_brk;
		if (!ref_ext && !ref_brk && b == SCAN_CAPS)
			ref_caps = !ref_caps;
		ref_ext = 1'b0;
		ref_brk = 1'b0;
	end
endfunction

`endif

// ==== bench/kbd_rx_tb.sv ====
`timescale 1ns/1ps

module kbd_rx_tb;
	import kbd_pkg::*;

	logic clk, reset;
	logic ps2_clk, ps2_data;
	logic credit_return = 1'b0;
	logic evt_valid, evt_release, evt_extended, frame_err, overflow;
	logic [7:0] evt_scan, evt_ascii;

	logic [17:0] sb [$]; // expected {scan, ascii, release, extended}
	logic ref_ext = 1'b0, ref_brk = 1'b0, ref_shift = 1'b0, ref_caps = 1'b0;
	logic exp_overflow = 1'b0;
	logic hold_credits = 1'b0;
	int hold_kept = 0; // events the reference keeps while credits are held
	logic [31:0] stim_rng = 32'h6efc;
	logic [31:0] credit_rng = 32'h6efc;
	int frames_sent = 0, cycles = 0;
	int err_value = 0, err_event = 0, err_frame = 0;
	int owed = 0, ret_wait = 0, evt_count = 0;
	int frame_err_seen = 0, frame_err_exp = 0;

	`include "kbd_rx_model.svh"

	tb_clock_gen i_tb_clock_gen (.clk, .reset);

	kbd_rx_top i_kbd_rx_top (
		.clk, .reset, .ps2_clk, .ps2_data, .credit_return,
		.evt_valid, .evt_scan, .evt_ascii, .evt_release, .evt_extended,
		.frame_err, .overflow
	);

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Fail %0t: %s got %02h expected %02h", $time, what, got, exp);
			err_value++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
			err_value++;
		end
	endtask

	task automatic send_key(input logic [7:0] b);
		ref_event(b); // event can pop before the frame task returns
		send_frame(b, 1'b0, 1'b0);
	endtask

	task automatic tap(input logic [7:0] code); // make then break
		send_key(code);
		send_key(SCAN_F0);
		send_key(code);
	endtask

	function automatic logic [7:0] pick_key();
		stim_rng = xorshift32(stim_rng);
		return (stim_rng % 36 < 26) ? LETTER_SCAN[stim_rng % 36] : DIGIT_SCAN[stim_rng % 36 - 26];
	endfunction

	task automatic wait_drain();
		int n;
		n = 0;
		while ((sb.size() != 0 || owed != 0) && n < 2000) begin
			@(posedge clk);
			n++;
		end
		if (sb.size() != 0) begin
			$display("%0d expected events never arrived", sb.size());
			err_event += sb.size();
			sb.delete();
		end
		repeat (4) @(posedge clk);
	endtask

	// outputs sampled one edge after the DUT set them
	always @(posedge clk) begin
		logic [17:0] e;
		if (frame_err)
			frame_err_seen++;
		if (evt_valid) begin
			evt_count++;
			if (sb.size() == 0) begin
				$display("unexpected event at %0t, scan %02h", $time, evt_scan);
				err_event++;
			end else begin
				e = sb.pop_front();
				check_byte("scan", evt_scan, e[17:10]);
				check_byte("ascii", evt_ascii, e[9:2]);
				check_flag("release", evt_release, e[1]);
				check_flag("extended", evt_extended, e[0]);
			end
		end
	end

	// consumer hands each credit back after a random delay
	always @(posedge clk) begin
		credit_return <= 1'b0;
		if (!reset) begin
			if (evt_valid)
				owed++;
			if (ret_wait > 0)
				ret_wait--;
			else if (owed > 0 && !hold_credits) begin
				credit_return <= 1'b1;
				owed--;
				credit_rng = xorshift32(credit_rng);
				ret_wait = credit_rng % 8;
			end
		end
	end

	// watchdog scaled by frames sent so far
	always @(posedge clk) begin
		cycles++;
		if (cycles > frames_sent * FRAME_BITS * 24 * 2 + 2000) begin
			$display("run stopped, no progress after %0d cycles", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		ps2_clk  = 1'b1; // idle high
		ps2_data = 1'b1;
		@(negedge reset);
		@(posedge clk);

		// plain make and break
		repeat (10) tap(pick_key());
		wait_drain();

		// shift, caps, both, then release
		send_key(SCAN_LSHIFT);
		repeat (3) tap(pick_key());
		tap(SCAN_CAPS);
		repeat (3) tap(pick_key());
		send_key(SCAN_F0);
		send_key(SCAN_LSHIFT);
		repeat (3) tap(pick_key()); // caps only
		tap(SCAN_CAPS);
		send_key(SCAN_RSHIFT);
		tap(pick_key());
		send_key(SCAN_F0);
		send_key(SCAN_RSHIFT);
		tap(pick_key());
		wait_drain();

		// extended keys and the fake shift E0 12
		foreach (DIGIT_SCAN[i]) begin
			if (i < 3) begin
				send_key(SCAN_E0);
				send_key(8'h75 - 8'(i * 3));
				send_key(SCAN_E0);
				send_key(SCAN_F0);
				send_key(8'h75 - 8'(i * 3));
			end
		end
		send_key(SCAN_E0);
		send_key(SCAN_LSHIFT);
		tap(LETTER_SCAN[0]);
		send_key(SCAN_E0);
		send_key(SCAN_F0);
		send_key(SCAN_LSHIFT);
		wait_drain();

		// bad parity, bad stop, cut frame
		send_frame(8'h1C, 1'b1, 1'b0);
		frame_err_exp++;
		send_frame(8'h32, 1'b0, 1'b1);
		frame_err_exp++;
		send_raw(11'h0F6, 5);
		repeat (BIT_TIMEOUT + 50) @(posedge clk);
		tap(pick_key());
		wait_drain();
		check_flag("overflow", overflow, exp_overflow); // nothing dropped so far

		// credits withheld until past capacity
		hold_credits = 1'b1;
		evt_count = 0;
		repeat (QUEUE_DEPTH + QUEUE_CREDITS + 3) send_key(pick_key());
		repeat (50) @(posedge clk);
		if (evt_count > QUEUE_CREDITS) begin
			$display("%0d events sent with only %0d credits", evt_count, QUEUE_CREDITS);
			err_event++;
		end
		hold_credits = 1'b0;
		wait_drain();

		check_flag("overflow", overflow, exp_overflow);
		if (frame_err_seen != frame_err_exp) begin
			$display("frame errors seen %0d, expected %0d", frame_err_seen, frame_err_exp);
			err_frame++;
		end
		$display("errors: value %0d, event %0d, frame %0d", err_value, err_event, err_frame);
		if (err_value + err_event + err_frame == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end
endmodule

// ==== kbd_rx.f ====
hdl/kbd_pkg.sv
hdl/ps2_frame_rx.sv
hdl/ps2_bit_timer.sv
hdl/kbd_protocol_fsm.sv
hdl/scan_to_ascii.sv
hdl/key_event_queue.sv
hdl/kbd_rx_top.sv
+incdir+bench
bench/tb_clock_gen.sv
bench/kbd_rx_checker.sv
bench/kbd_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the kbd_rx simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f kbd_rx.f --top-module kbd_rx_tb \
	--Mdir obj_dir -o kbd_rx_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/kbd_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0
